//--- include/cpu_settings.svh
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

`define CPU_DATA_WIDTH 32
`define CPU_REGISTER_COUNT 32 // x0 is not stored
`define CPU_STATION_COUNT 4
`define CPU_TAG_WIDTH 2 // Enough to name every station
`define CPU_INSTRUCTION_BYTES 4

`endif

//--- source/cpu_package.sv
`include "cpu_settings.svh"

package cpu_package;
    typedef logic [`CPU_DATA_WIDTH-1:0] data_t;
    typedef logic [`CPU_TAG_WIDTH-1:0] tag_t;

    typedef enum logic [6:0] {
        OPCODE_OP     = 7'b0110011,
        OPCODE_OP_IMM = 7'b0010011,
        OPCODE_LUI    = 7'b0110111,
        OPCODE_BRANCH = 7'b1100011,
        OPCODE_JAL    = 7'b1101111
    } opcode_t;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_OR   = 4'd2,
        ALU_AND  = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLL  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_SLTU = 4'd8,
        ALU_SLT  = 4'd9
    } alu_operation_t;

    typedef enum logic [1:0] {
        IDLE,
        WAITING,
        HOLDING,
        CANCELING
    } fetch_state_t;
endpackage

//--- source/instruction_fetch.sv
`include "cpu_settings.svh"

module instruction_fetch (
    input  logic clock,
    input  logic reset,
    output cpu_package::data_t memory_address,
    input  cpu_package::data_t memory_data_in,
    output logic memory_enable,
    input  logic memory_ready,
    output logic instruction_valid,
    output logic [31:0] instruction,
    output cpu_package::data_t instruction_pc,
    input  logic instruction_taken,
    input  logic redirect_valid,
    input  cpu_package::data_t redirect_target
);
    import cpu_package::*;

    fetch_state_t state;
    data_t program_counter;
    logic start_fetch;
    logic fetch_done;

    assign start_fetch = state == IDLE && !memory_ready; // Previous ready must be gone
    assign fetch_done = state == WAITING && memory_ready && !redirect_valid;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= IDLE;
            program_counter <= '0;
            memory_enable <= 1'b0;
            instruction_valid <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (start_fetch) begin
                        memory_enable <= 1'b1;
                        state <= WAITING;
                    end
                end
                WAITING: begin
                    if (redirect_valid) begin
                        program_counter <= redirect_target;
                        state <= CANCELING; // Word in flight is stale
                    end else if (memory_ready) begin
                        memory_enable <= 1'b0;
                        instruction_valid <= 1'b1;
                        program_counter <= program_counter + `CPU_INSTRUCTION_BYTES;
                        state <= HOLDING;
                    end
                end
                HOLDING: begin
                    if (instruction_taken) begin
                        instruction_valid <= 1'b0;
                        if (redirect_valid) program_counter <= redirect_target;
                        state <= IDLE;
                    end
                end
                CANCELING: begin
                    if (memory_ready) begin
                        memory_enable <= 1'b0; // Data dropped
                        state <= IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (start_fetch) memory_address <= program_counter;
        if (fetch_done) begin
            instruction <= memory_data_in;
            instruction_pc <= program_counter;
        end
    end

    assert property (@(posedge clock) disable iff (reset)
        memory_enable && $past(memory_enable) |-> $stable(memory_address));
endmodule

//--- source/issue_unit.sv
`include "cpu_settings.svh"

module issue_unit #(
    parameter int station_count = `CPU_STATION_COUNT
) (
    input  logic clock,
    input  logic reset,
    input  logic instruction_valid,
    input  logic [31:0] instruction,
    input  cpu_package::data_t instruction_pc,
    output logic instruction_taken,
    output logic redirect_valid,
    output cpu_package::data_t redirect_target,
    output logic [4:0] source_1_index,
    output logic [4:0] source_2_index,
    input  cpu_package::data_t source_1_value,
    input  logic source_1_ready,
    input  cpu_package::tag_t source_1_tag,
    input  cpu_package::data_t source_2_value,
    input  logic source_2_ready,
    input  cpu_package::tag_t source_2_tag,
    output logic reserve_valid,
    output logic [4:0] reserve_index,
    output cpu_package::tag_t reserve_tag,
    output logic direct_write_valid,
    output logic [4:0] direct_write_index,
    output cpu_package::data_t direct_write_value,
    input  logic [station_count-1:0] station_busy,
    output logic dispatch_valid,
    output logic [station_count-1:0] dispatch_select,
    output cpu_package::alu_operation_t dispatch_operation,
    output cpu_package::data_t dispatch_value_1,
    output cpu_package::data_t dispatch_value_2,
    output logic dispatch_ready_1,
    output logic dispatch_ready_2,
    output cpu_package::tag_t dispatch_tag_1,
    output cpu_package::tag_t dispatch_tag_2,
    input  logic bus_valid
);
    import cpu_package::*;

    opcode_t opcode;
    logic [2:0] function_3;
    logic [4:0] destination_index;
    data_t immediate;
    data_t immediate_branch;
    data_t immediate_upper;
    data_t immediate_jump;
    logic [station_count-1:0] station_free;
    logic is_alu;
    logic writes_direct;
    logic branch_taken;

    assign opcode = opcode_t'(instruction[6:0]);
    assign function_3 = instruction[14:12];
    assign destination_index = instruction[11:7];

    assign immediate = {{21{instruction[31]}}, instruction[30:20]};
    assign immediate_branch = {{20{instruction[31]}}, instruction[7], instruction[30:25],
                               instruction[11:8], 1'b0};
    assign immediate_upper = {instruction[31:12], 12'b0};
    assign immediate_jump = {{12{instruction[31]}}, instruction[19:12], instruction[20],
                             instruction[30:21], 1'b0};

    assign is_alu = opcode == OPCODE_OP || opcode == OPCODE_OP_IMM;
    assign writes_direct = opcode == OPCODE_LUI || opcode == OPCODE_JAL;

    // LUI and JAL have no rs1, so port 1 checks whether rd is still pending
    assign source_1_index = writes_direct ? destination_index : instruction[19:15];
    assign source_2_index = instruction[24:20];

    assign station_free = ~station_busy;
    assign dispatch_select = station_free & (~station_free + 1'b1); // Lowest free

    always_comb begin
        case (opcode)
            OPCODE_OP, OPCODE_OP_IMM: instruction_taken = instruction_valid && |station_free;
            OPCODE_LUI, OPCODE_JAL: instruction_taken = instruction_valid && source_1_ready
                                                        && !bus_valid;
            OPCODE_BRANCH: instruction_taken = instruction_valid && source_1_ready
                                               && source_2_ready;
            default: instruction_taken = instruction_valid; // Unsupported, dropped
        endcase
    end

    always_comb begin
        case (function_3)
            3'b000: branch_taken = source_1_value == source_2_value;
            3'b001: branch_taken = source_1_value != source_2_value;
            3'b100: branch_taken = $signed(source_1_value) < $signed(source_2_value);
            3'b101: branch_taken = $signed(source_1_value) >= $signed(source_2_value);
            3'b110: branch_taken = source_1_value < source_2_value;
            3'b111: branch_taken = source_1_value >= source_2_value;
            default: branch_taken = 1'b0;
        endcase
    end

    assign redirect_valid = instruction_taken
                            && (opcode == OPCODE_JAL || (opcode == OPCODE_BRANCH && branch_taken));
    assign redirect_target = instruction_pc
                             + (opcode == OPCODE_JAL ? immediate_jump : immediate_branch);

    always_comb begin
        case (function_3)
            3'b000: dispatch_operation = (opcode == OPCODE_OP && instruction[30]) ? ALU_SUB
                                                                                  : ALU_ADD;
            3'b001: dispatch_operation = ALU_SLL;
            3'b010: dispatch_operation = ALU_SLT;
            3'b011: dispatch_operation = ALU_SLTU;
            3'b100: dispatch_operation = ALU_XOR;
            3'b101: dispatch_operation = instruction[30] ? ALU_SRA : ALU_SRL;
            3'b110: dispatch_operation = ALU_OR;
            default: dispatch_operation = ALU_AND;
        endcase
    end

    assign dispatch_valid = instruction_taken && is_alu;
    assign dispatch_value_1 = source_1_value;
    assign dispatch_ready_1 = source_1_ready;
    assign dispatch_tag_1 = source_1_tag;
    assign dispatch_value_2 = opcode == OPCODE_OP_IMM ? immediate : source_2_value;
    assign dispatch_ready_2 = opcode == OPCODE_OP_IMM || source_2_ready;
    assign dispatch_tag_2 = source_2_tag;

    always_comb begin
        reserve_tag = '0;
        for (int i = 0; i < station_count; i++) begin
            if (dispatch_select[i]) reserve_tag = tag_t'(i);
        end
    end

    assign reserve_valid = dispatch_valid && destination_index != 5'd0;
    assign reserve_index = destination_index;

    assign direct_write_valid = instruction_taken && writes_direct && destination_index != 5'd0;
    assign direct_write_index = destination_index;
    assign direct_write_value = opcode == OPCODE_JAL ? instruction_pc + `CPU_INSTRUCTION_BYTES
                                                     : immediate_upper;

    // Held instruction must wait unchanged until taken
    assert property (@(posedge clock) disable iff (reset)
        instruction_valid && !instruction_taken |=> instruction_valid && $stable(instruction));
endmodule

//--- source/register_status.sv
`include "cpu_settings.svh"

module register_status (
    input  logic clock,
    input  logic reset,
    input  logic [4:0] source_1_index,
    output cpu_package::data_t source_1_value,
    output logic source_1_ready,
    output cpu_package::tag_t source_1_tag,
    input  logic [4:0] source_2_index,
    output cpu_package::data_t source_2_value,
    output logic source_2_ready,
    output cpu_package::tag_t source_2_tag,
    input  logic reserve_valid,
    input  logic [4:0] reserve_index,
    input  cpu_package::tag_t reserve_tag,
    input  logic direct_write_valid,
    input  logic [4:0] direct_write_index,
    input  cpu_package::data_t direct_write_value,
    input  logic bus_valid,
    input  cpu_package::tag_t bus_tag,
    input  cpu_package::data_t bus_value,
    output logic write_valid,
    output logic [4:0] write_index,
    output cpu_package::data_t write_value
);
    import cpu_package::*;

    data_t values [1:`CPU_REGISTER_COUNT-1];
    tag_t tags [1:`CPU_REGISTER_COUNT-1];
    logic [`CPU_REGISTER_COUNT-1:1] busy;
    logic bus_hit;
    logic [4:0] bus_index;

    function automatic logic on_bus(input logic [4:0] index);
        return busy[index] && bus_valid && bus_tag == tags[index];
    endfunction

    function automatic data_t read_value(input logic [4:0] index);
        if (index == 5'd0) return '0;
        if (on_bus(index)) return bus_value; // Forwarded
        return values[index];
    endfunction

    assign source_1_value = read_value(source_1_index);
    assign source_1_ready = source_1_index == 5'd0 || !busy[source_1_index]
                            || on_bus(source_1_index);
    assign source_1_tag = source_1_index == 5'd0 ? '0 : tags[source_1_index];
    assign source_2_value = read_value(source_2_index);
    assign source_2_ready = source_2_index == 5'd0 || !busy[source_2_index]
                            || on_bus(source_2_index);
    assign source_2_tag = source_2_index == 5'd0 ? '0 : tags[source_2_index];

    // Result may belong to no register if rd was x0 or renamed since
    always_comb begin
        bus_hit = 1'b0;
        bus_index = '0;
        for (int i = 1; i < `CPU_REGISTER_COUNT; i++) begin
            if (on_bus(5'(i))) begin
                bus_hit = 1'b1;
                bus_index = 5'(i);
            end
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            busy <= '0;
            write_valid <= 1'b0;
        end else begin
            write_valid <= bus_hit || direct_write_valid;
            if (bus_hit) busy[bus_index] <= 1'b0;
            if (reserve_valid) busy[reserve_index] <= 1'b1; // Wins over the clear
        end
    end

    always_ff @(posedge clock) begin
        if (bus_hit) begin
            values[bus_index] <= bus_value;
            write_index <= bus_index;
            write_value <= bus_value;
        end
        if (direct_write_valid) begin
            values[direct_write_index] <= direct_write_value;
            write_index <= direct_write_index;
            write_value <= direct_write_value;
        end
        if (reserve_valid) tags[reserve_index] <= reserve_tag;
    end

    assert property (@(posedge clock) disable iff (reset) !(direct_write_valid && bus_valid));
endmodule

//--- source/alu_station.sv
module alu_station (
    input  logic clock,
    input  logic reset,
    input  logic dispatch_load,
    input  cpu_package::alu_operation_t operation,
    input  cpu_package::data_t value_1,
    input  cpu_package::data_t value_2,
    input  logic ready_1,
    input  logic ready_2,
    input  cpu_package::tag_t tag_1,
    input  cpu_package::tag_t tag_2,
    input  logic bus_valid,
    input  cpu_package::tag_t bus_tag,
    input  cpu_package::data_t bus_value,
    input  logic grant,
    output logic busy,
    output logic request,
    output cpu_package::data_t result
);
    import cpu_package::*;

    alu_operation_t held_operation;
    data_t operand_1;
    data_t operand_2;
    tag_t wait_tag_1;
    tag_t wait_tag_2;
    logic have_1;
    logic have_2;
    logic capture_1;
    logic capture_2;
    logic [4:0] shift;

    assign capture_1 = busy && !have_1 && bus_valid && bus_tag == wait_tag_1;
    assign capture_2 = busy && !have_2 && bus_valid && bus_tag == wait_tag_2;
    assign request = busy && have_1 && have_2;
    assign shift = operand_2[4:0];

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            busy <= 1'b0;
            have_1 <= 1'b0;
            have_2 <= 1'b0;
        end else if (dispatch_load) begin
            busy <= 1'b1;
            have_1 <= ready_1;
            have_2 <= ready_2;
        end else begin
            if (grant) busy <= 1'b0; // Result goes out next cycle
            if (capture_1) have_1 <= 1'b1;
            if (capture_2) have_2 <= 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (dispatch_load) begin
            held_operation <= operation;
            operand_1 <= value_1;
            operand_2 <= value_2;
            wait_tag_1 <= tag_1;
            wait_tag_2 <= tag_2;
        end else begin
            if (capture_1) operand_1 <= bus_value;
            if (capture_2) operand_2 <= bus_value;
        end
    end

    always_comb begin
        case (held_operation)
            ALU_ADD: result = operand_1 + operand_2;
            ALU_SUB: result = operand_1 - operand_2;
            ALU_OR: result = operand_1 | operand_2;
            ALU_AND: result = operand_1 & operand_2;
            ALU_XOR: result = operand_1 ^ operand_2;
            ALU_SLL: result = operand_1 << shift;
            ALU_SRL: result = operand_1 >> shift;
            ALU_SRA: result = $signed(operand_1) >>> shift;
            ALU_SLTU: result = data_t'(operand_1 < operand_2);
            ALU_SLT: result = data_t'($signed(operand_1) < $signed(operand_2));
            default: result = '0;
        endcase
    end
endmodule

//--- source/result_bus.sv
`include "cpu_settings.svh"

module result_bus #(
    parameter int station_count = `CPU_STATION_COUNT
) (
    input  logic clock,
    input  logic reset,
    input  logic [station_count-1:0] request,
    input  cpu_package::data_t results [station_count],
    output logic [station_count-1:0] grant,
    output logic bus_valid,
    output cpu_package::tag_t bus_tag,
    output cpu_package::data_t bus_value
);
    import cpu_package::*;

    tag_t winner;

    // Fixed priority, station 0 first
    always_comb begin
        grant = '0;
        winner = '0;
        for (int i = station_count - 1; i >= 0; i--) begin
            if (request[i]) begin
                grant = '0;
                grant[i] = 1'b1;
                winner = tag_t'(i);
            end
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) bus_valid <= 1'b0;
        else bus_valid <= |request;
    end

    always_ff @(posedge clock) begin
        bus_tag <= winner;
        bus_value <= results[winner];
    end

    // A granted station must have freed itself
    assert property (@(posedge clock) disable iff (reset)
        |grant |=> (request & $past(grant)) == '0);
endmodule

//--- source/cpu.sv
`include "cpu_settings.svh"

module cpu #(
    parameter int station_count = `CPU_STATION_COUNT
) (
    input  logic clock,
    input  logic reset,
    output cpu_package::data_t memory_address,
    input  cpu_package::data_t memory_data_in,
    output logic memory_enable,
    input  logic memory_ready,
    output logic write_valid,
    output logic [4:0] write_index,
    output cpu_package::data_t write_value
);
    import cpu_package::*;

    logic instruction_valid, instruction_taken, redirect_valid;
    logic [31:0] instruction;
    data_t instruction_pc, redirect_target;
    logic [4:0] source_1_index, source_2_index;
    data_t source_1_value, source_2_value;
    logic source_1_ready, source_2_ready;
    tag_t source_1_tag, source_2_tag;
    logic reserve_valid, direct_write_valid;
    logic [4:0] reserve_index, direct_write_index;
    tag_t reserve_tag;
    data_t direct_write_value;
    logic dispatch_valid, dispatch_ready_1, dispatch_ready_2;
    logic [station_count-1:0] dispatch_select, station_busy, station_request, station_grant;
    alu_operation_t dispatch_operation;
    data_t dispatch_value_1, dispatch_value_2;
    tag_t dispatch_tag_1, dispatch_tag_2;
    data_t station_results [station_count];
    logic bus_valid;
    tag_t bus_tag;
    data_t bus_value;

    instruction_fetch u_fetch (.*);

    issue_unit #(.station_count(station_count)) u_issue (.*);

    register_status u_registers (.*);

    result_bus #(.station_count(station_count)) u_bus (
        .clock, .reset,
        .request(station_request),
        .results(station_results),
        .grant(station_grant),
        .bus_valid, .bus_tag, .bus_value
    );

    for (genvar i = 0; i < station_count; i++) begin : g_station
        alu_station u_station (
            .clock, .reset,
            .dispatch_load(dispatch_valid && dispatch_select[i]),
            .operation(dispatch_operation),
            .value_1(dispatch_value_1),
            .value_2(dispatch_value_2),
            .ready_1(dispatch_ready_1),
            .ready_2(dispatch_ready_2),
            .tag_1(dispatch_tag_1),
            .tag_2(dispatch_tag_2),
            .bus_valid, .bus_tag, .bus_value,
            .grant(station_grant[i]),
            .busy(station_busy[i]),
            .request(station_request[i]),
            .result(station_results[i])
        );
    end
endmodule

//--- sim/cpu_testbench.sv
module cpu_testbench;
    import cpu_package::*;

    localparam int image_words = 64; // Program image, words 00-3F
    localparam int end_word = 'h40; // End address, expected x1-x31 follow

    logic clock;
    logic reset;
    data_t memory_address;
    data_t memory_data_in;
    logic memory_enable;
    logic memory_ready;
    logic write_valid;
    logic [4:0] write_index;
    data_t write_value;

    logic [31:0] testdata [0:'h5F];
    data_t shadow [0:31];
    data_t end_address;
    logic end_reached;
    logic [15:0] lfsr_state;

    cpu u_dut (
        .clock,
        .reset,
        .memory_address,
        .memory_data_in,
        .memory_enable,
        .memory_ready,
        .write_valid,
        .write_index,
        .write_value
    );

    task automatic stop_run(input string reason);
        $display("%s", reason);
        $display("RESULT: FAIL");
        $fatal(1);
    endtask

    // Galois form, taps 16 14 13 11
    function automatic logic random_bit();
        logic taken;
        taken = lfsr_state[0];
        lfsr_state = {1'b0, lfsr_state[15:1]} ^ (taken ? 16'hB400 : 16'h0000);
        return taken;
    endfunction

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    initial begin : memory_model
        int idle_cycles;
        int hold_cycles;
        logic [1:0] latency;
        logic first_request;
        memory_ready = 1'b0;
        memory_data_in = '0;
        first_request = 1'b1;
        forever begin
            idle_cycles = 0;
            while (memory_enable !== 1'b1) begin
                @(negedge clock);
                idle_cycles++;
                if (idle_cycles > 200) stop_run("Timeout while waiting for a fetch request");
            end
            if (first_request) begin
                assert (memory_address === '0)
                else stop_run($sformatf(
                    "Error: memory_address is %h on the first fetch, expected 00000000",
                    memory_address));
                first_request = 1'b0;
            end
            assert (memory_address < image_words * 4)
            else stop_run("The core fetched outside the program image");
            if (memory_address == end_address) end_reached = 1'b1;
            latency[0] = random_bit();
            latency[1] = random_bit();
            repeat (latency) @(negedge clock); // 0 to 3 extra cycles
            memory_data_in = testdata[memory_address >> 2];
            memory_ready = 1'b1;
            hold_cycles = 0;
            while (memory_enable !== 1'b0) begin
                @(negedge clock);
                hold_cycles++;
                if (hold_cycles > 50)
                    stop_run("Timeout while waiting for the core to drop memory_enable");
            end
            memory_ready = 1'b0;
        end
    end

    // Shadow file follows the write trace
    always @(negedge clock) begin
        if (reset === 1'b0 && write_valid === 1'b1) begin
            assert (write_index != 5'd0)
            else stop_run($sformatf("Error: write_index is %h on a trace write", write_index));
            shadow[write_index] = write_value;
        end
    end

    initial begin
        int cycles;
        int quiet_cycles;
        reset = 1'b1;
        end_reached = 1'b0;
        lfsr_state = 16'd21085;
        for (int i = 0; i < 32; i++) shadow[i] = '0;
        for (int i = 0; i <= 'h5F; i++) testdata[i] = 32'hBAD0_0000 | i;
        $readmemh("sim/cpu_testdata.hex", testdata);
        end_address = testdata[end_word];
        assert (opcode_t'(testdata[end_address >> 2][6:0]) == OPCODE_JAL)
        else stop_run("The end address of the test program does not hold a JAL");

        repeat (2) @(negedge clock);
        assert (memory_enable === 1'b0)
        else stop_run($sformatf("Error: memory_enable is %h after reset, expected 0", memory_enable));
        assert (write_valid === 1'b0)
        else stop_run($sformatf("Error: write_valid is %h after reset, expected 0", write_valid));
        reset = 1'b0;

        cycles = 0;
        while (!end_reached) begin
            @(negedge clock);
            cycles++;
            if (cycles > 5000) stop_run("Timeout: the program never reached its end address");
        end

        // Stations may still hold results
        quiet_cycles = 0;
        cycles = 0;
        while (quiet_cycles < 20) begin
            @(negedge clock);
            cycles++;
            quiet_cycles = write_valid ? 0 : quiet_cycles + 1;
            if (cycles > 1000) stop_run("Timeout: register writes never settled after the end");
        end

        for (int i = 1; i < 32; i++) begin
            assert (shadow[i] === testdata[end_word + i])
            else stop_run($sformatf("Error: register x%0d expected %h got %h",
                                    i, testdata[end_word + i], shadow[i]));
        end
        $display("RESULT: PASS");
        $finish;
    end
endmodule

//--- verilog.f
+incdir+include
source/cpu_package.sv
source/instruction_fetch.sv
source/issue_unit.sv
source/register_status.sv
source/alu_station.sv
source/result_bus.sv
source/cpu.sv
sim/cpu_testbench.sv

//--- sim/cpu_testdata.hex
// Words 00-3F program image, two instructions per line
// Word 40 end address, words 41-5F expected final values of x1-x31
@00
00500093 FFD00113 // 00 addi x1,x0,5       addi x2,x0,-3
002081B3 40208233 // 08 add x3,x1,x2       sub x4,x1,x2
001122B3 00113333 // 10 slt x5,x2,x1       sltu x6,x2,x1
0F014393 7000E413 // 18 xori x7,x2,0x0f0   ori x8,x1,0x700
0FF17493 00409513 // 20 andi x9,x2,0x0ff   slli x10,x1,4
40115593 01C15613 // 28 srai x11,x2,1      srli x12,x2,28
123456B7 0086D733 // 30 lui x13,0x12345    srl x14,x13,x8
4013D7B3 FFF0B813 // 38 sra x15,x7,x1      sltiu x16,x1,-1
FFE12893 0041C933 // 40 slti x17,x2,-2     xor x18,x3,x4
00D969B3 0079FA33 // 48 or x19,x18,x13     and x20,x19,x7
001A0A93 015A8AB3 // 50 addi x21,x20,1     add x21,x21,x21
01512B33 00708013 // 58 slt x22,x2,x21     addi x0,x1,7
00000B93 00000C13 // 60 addi x23,x0,0      addi x24,x0,0
00108463 001C6C13 // 68 beq x1,x1 taken    ori x24,x24,0x01
016A8463 001BEB93 // 70 beq x21,x22 not    ori x23,x23,0x01
00209463 002C6C13 // 78 bne x1,x2 taken    ori x24,x24,0x02
00109463 002BEB93 // 80 bne x1,x1 not      ori x23,x23,0x02
00114463 004C6C13 // 88 blt x2,x1 taken    ori x24,x24,0x04
0020C463 004BEB93 // 90 blt x1,x2 not      ori x23,x23,0x04
0020D463 008C6C13 // 98 bge x1,x2 taken    ori x24,x24,0x08
00115463 008BEB93 // a0 bge x2,x1 not      ori x23,x23,0x08
0020E463 010C6C13 // a8 bltu x1,x2 taken   ori x24,x24,0x10
00116463 010BEB93 // b0 bltu x2,x1 not     ori x23,x23,0x10
00117463 020C6C13 // b8 bgeu x2,x1 taken   ori x24,x24,0x20
0020F463 020BEB93 // c0 bgeu x1,x2 not     ori x23,x23,0x20
00800CEF 040C6C13 // c8 jal x25,+8         ori x24,x24,0x40
FEDCBD37 0000006F // d0 lui x26,0xfedcb    jal x0,0
@40
000000D4 // end address
00000005 FFFFFFFD 00000002 00000008 // x1-x4
00000001 00000000 FFFFFF0D 00000705 // x5-x8
000000FD 00000050 FFFFFFFE 0000000F // x9-x12
12345000 0091A280 FFFFFFF8 00000001 // x13-x16
00000001 0000000A 1234500A 12345008 // x17-x20
2468A012 00000001 0000003F 00000000 // x21-x24, x23 untaken markers, x24 skipped
000000CC FEDCB000 00000000 00000000 // x25-x28
00000000 00000000 00000000 // x29-x31
